//--- hdl/proc_pkg.sv
/*
   Shared types for the 16-bit pipelined processor
   Word and register index types, opcode and function codes
   Instruction formats and the instruction union
   Control bundle, pipeline register layouts, writeback and Wishbone request
*/
`default_nettype none

package proc_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   localparam logic [4:0] OP_ADD_R = 5'b11011;   // R-format ALU group, func selects op
   localparam logic [4:0] OP_ADDI  = 5'b01000;
   localparam logic [4:0] OP_LD    = 5'b10001;
   localparam logic [4:0] OP_ST    = 5'b10000;
   localparam logic [4:0] OP_BEQZ  = 5'b01100;
   localparam logic [4:0] OP_NOP   = 5'b00001;
   localparam logic [4:0] OP_HALT  = 5'b00000;

   localparam logic [1:0] FN_ADD = 2'b00;
   localparam logic [1:0] FN_SUB = 2'b01;
   localparam logic [1:0] FN_AND = 2'b10;
   localparam logic [1:0] FN_XOR = 2'b11;

   typedef struct packed {
      logic [4:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [1:0] func;
   } r_fmt_t;

   typedef struct packed {
      logic [4:0] opcode;
      reg_idx_t   rs;
      reg_idx_t   rd;      // Destination, or store data for ST
      logic [4:0] imm5;
   } i_fmt_t;

   typedef struct packed {
      logic [4:0] opcode;
      reg_idx_t   rs;
      logic [7:0] imm8;
   } b_fmt_t;

   // One instruction word, viewed by format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      b_fmt_t b;
   } instr_t;

   typedef struct packed {
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
      logic       alu_src;   // Immediate as second operand
      logic       branch;
      logic       halt;
      logic [1:0] alu_op;
   } ctrl_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      reg_idx_t dest;
      word_t    pc;
   } id_ex_t;

   typedef struct packed {
      logic     valid;
      ctrl_t    ctrl;
      word_t    result;
      word_t    store_data;
      reg_idx_t dest;
   } ex_mem_t;

   typedef struct packed {
      logic     write;
      reg_idx_t dest;
      word_t    data;
   } wb_t;

   // Wishbone classic master outputs
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      word_t adr;
      word_t dat;
   } bus_req_t;

endpackage

`default_nettype wire

//--- hdl/pipe_control.sv
/*
   Pipeline control
   Opcode decode into the control bundle
   RAW hazard check against EX and MEM destinations
   Stall, flush and freeze generation, sticky illegal-opcode error
*/
`timescale 1ns/100ps
`default_nettype none

module pipe_control (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire proc_pkg::instr_t   instr,
   input  wire proc_pkg::reg_idx_t ex_dest,
   input  wire proc_pkg::reg_idx_t mem_dest,
   input  wire logic               ex_wr,
   input  wire logic               mem_wr,
   input  wire logic               branch_taken,
   input  wire logic               mem_busy,
   input  wire logic               halted,
   output proc_pkg::ctrl_t         ctrl,
   output logic                    stall,
   output logic                    flush,
   output logic                    freeze,
   output logic                    err
);
   import proc_pkg::*;

   reg_idx_t src_a;
   reg_idx_t src_b;
   logic     use_a;
   logic     use_b;
   logic     illegal;
   logic     hazard;

   always_comb begin
      ctrl    = '0;
      src_a   = instr.i.rs;
      src_b   = instr.r.rt;   // Also the ST data register
      use_a   = 1'b0;
      use_b   = 1'b0;
      illegal = 1'b0;
      case (instr.r.opcode)
         OP_ADD_R: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_op    = instr.r.func;
            use_a          = 1'b1;
            use_b          = 1'b1;
         end
         OP_ADDI: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = FN_ADD;
            use_a          = 1'b1;
         end
         OP_LD: begin
            ctrl.reg_write = 1'b1;
            ctrl.mem_read  = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = FN_ADD;   // Address is rs + imm
            use_a          = 1'b1;
         end
         OP_ST: begin
            ctrl.mem_write = 1'b1;
            ctrl.alu_src   = 1'b1;
            ctrl.alu_op    = FN_ADD;
            use_a          = 1'b1;
            use_b          = 1'b1;
         end
         OP_BEQZ: begin
            ctrl.branch = 1'b1;
            use_a       = 1'b1;
         end
         OP_NOP:  ctrl = '0;
         OP_HALT: ctrl.halt = 1'b1;
         default: illegal = 1'b1;   // Runs as NOP
      endcase
   end

   assign hazard = (use_a && ((ex_wr && ex_dest == src_a) || (mem_wr && mem_dest == src_a))) ||
                   (use_b && ((ex_wr && ex_dest == src_b) || (mem_wr && mem_dest == src_b)));

   // Freeze beats flush beats stall
   assign freeze = mem_busy;
   assign flush  = branch_taken && !freeze;
   assign stall  = hazard && !halted && !flush && !freeze;

   // Only counted once the slot is known to survive
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err <= 1'b0;
      end else if (illegal && !freeze && !flush && !halted) begin
         err <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
/*
   Instruction fetch
   Program counter with branch redirect and hold
   IF/ID pipeline register
*/
`timescale 1ns/100ps
`default_nettype none

module fetch_stage #(
   parameter int PC_W = 8
) (
   input  wire logic             clk,
   input  wire logic             rst_n,
   output logic [PC_W-1:0]       imem_addr,
   input  wire proc_pkg::word_t  imem_data,
   input  wire logic             stall,
   input  wire logic             flush,
   input  wire logic             freeze,
   input  wire logic             halted,
   input  wire logic             branch_taken,
   input  wire logic [PC_W-1:0]  branch_target,
   output proc_pkg::instr_t      if_instr,
   output proc_pkg::word_t       if_pc,
   output logic                  if_valid
);
   import proc_pkg::*;

   localparam word_t NOP_WORD = {OP_NOP, 11'd0};   // Empty slot decodes as NOP

   logic [PC_W-1:0] pc;

   assign imem_addr = pc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (!freeze && !halted) begin
         if (branch_taken) begin
            pc <= branch_target;
         end else if (!stall) begin
            pc <= pc + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         if_valid <= 1'b0;
         if_instr <= NOP_WORD;
      end else if (!freeze) begin
         if (flush || halted) begin
            if_valid <= 1'b0;
            if_instr <= NOP_WORD;
         end else if (!stall) begin
            if_valid <= 1'b1;
            if_instr <= imem_data;
            if_pc    <= word_t'(pc);
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
/*
   Instruction decode
   Eight-entry register file with write-through to the readers
   Immediate sign extension and destination select
   ID/EX pipeline register with bubble insertion
*/
`timescale 1ns/100ps
`default_nettype none

module decode_stage (
   input  wire logic             clk,
   input  wire logic             rst_n,
   input  wire proc_pkg::instr_t if_instr,
   input  wire proc_pkg::word_t  if_pc,
   input  wire logic             if_valid,
   input  wire proc_pkg::ctrl_t  ctrl,
   input  wire logic             stall,
   input  wire logic             flush,
   input  wire logic             freeze,
   input  wire proc_pkg::wb_t    wb,
   output proc_pkg::id_ex_t      id_ex
);
   import proc_pkg::*;

   word_t    regs [8];
   word_t    rs_val;
   word_t    rt_val;
   word_t    imm;
   reg_idx_t dest;

   always_ff @(posedge clk) begin
      if (wb.write) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // Same-cycle writeback goes straight to the reader
   assign rs_val = (wb.write && wb.dest == if_instr.r.rs) ? wb.data : regs[if_instr.r.rs];
   assign rt_val = (wb.write && wb.dest == if_instr.r.rt) ? wb.data : regs[if_instr.r.rt];

   // Branch offset is imm8, everything else imm5
   assign imm = ctrl.branch ? {{8{if_instr.b.imm8[7]}}, if_instr.b.imm8}
                            : {{11{if_instr.i.imm5[4]}}, if_instr.i.imm5};

   assign dest = ctrl.alu_src ? if_instr.i.rd : if_instr.r.rd;   // I-format vs R-format

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         id_ex.valid <= 1'b0;
      end else if (!freeze) begin
         if (stall || flush) begin
            id_ex.valid <= 1'b0;   // Bubble
         end else begin
            id_ex.valid  <= if_valid;
            id_ex.ctrl   <= ctrl;
            id_ex.rs_val <= rs_val;
            id_ex.rt_val <= rt_val;
            id_ex.imm    <= imm;
            id_ex.dest   <= dest;
            id_ex.pc     <= if_pc;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
/*
   Execute
   ALU for add, sub, and, xor with register or immediate operand
   BEQZ resolution and target computation
   EX/MEM pipeline register
*/
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire proc_pkg::id_ex_t  id_ex,
   input  wire logic              freeze,
   output logic                   branch_taken,
   output proc_pkg::word_t        branch_target,
   output proc_pkg::ex_mem_t      ex_mem
);
   import proc_pkg::*;

   word_t op_b;
   word_t alu_out;

   assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rt_val;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         FN_ADD:  alu_out = id_ex.rs_val + op_b;
         FN_SUB:  alu_out = id_ex.rs_val - op_b;   // rd = rs - rt
         FN_AND:  alu_out = id_ex.rs_val & op_b;
         default: alu_out = id_ex.rs_val ^ op_b;
      endcase
   end

   // Taken when rs is zero
   assign branch_taken  = id_ex.valid && id_ex.ctrl.branch && (id_ex.rs_val == '0);
   assign branch_target = id_ex.pc + 16'd1 + id_ex.imm;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_mem.valid <= 1'b0;
      end else if (!freeze) begin
         ex_mem.valid      <= id_ex.valid;
         ex_mem.ctrl       <= id_ex.ctrl;
         ex_mem.result     <= alu_out;   // Also the LD/ST address
         ex_mem.store_data <= id_ex.rt_val;
         ex_mem.dest       <= id_ex.dest;
      end
   end

endmodule

`default_nettype wire

//--- hdl/mem_stage.sv
/*
   Memory access and writeback
   Wishbone classic master, one transfer per LD or ST
   Writeback select between load data and ALU result
   Halt latch
*/
`timescale 1ns/100ps
`default_nettype none

module mem_stage (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire proc_pkg::ex_mem_t  ex_mem,
   output proc_pkg::bus_req_t      wb_req,
   input  wire proc_pkg::word_t    wb_dat_i,
   input  wire logic               wb_ack,
   output logic                    mem_busy,
   output logic                    halted,
   output proc_pkg::wb_t           wb
);
   import proc_pkg::*;

   logic mem_op;
   logic cyc_q;
   logic ack_ok;
   logic do_write;

   assign mem_op = ex_mem.valid && (ex_mem.ctrl.mem_read || ex_mem.ctrl.mem_write);
   assign ack_ok = cyc_q && wb_ack;

   // Pipeline holds from the first MEM cycle until ack
   assign mem_busy = mem_op && !halted && !ack_ok;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cyc_q <= 1'b0;
      end else if (ack_ok) begin
         cyc_q <= 1'b0;   // Low in the cycle after ack
      end else if (mem_op && !halted) begin
         cyc_q <= 1'b1;
      end
   end

   // EX/MEM is frozen during the transfer, so address and data stay put
   assign wb_req = '{cyc: cyc_q,
                     stb: cyc_q,
                     we:  ex_mem.ctrl.mem_write,
                     adr: ex_mem.result,
                     dat: ex_mem.store_data};

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         halted <= 1'b0;
      end else if (ex_mem.valid && ex_mem.ctrl.halt) begin
         halted <= 1'b1;
      end
   end

   // Loads write on ack, everything else in its one MEM cycle
   assign do_write = ex_mem.valid && ex_mem.ctrl.reg_write && !halted &&
                     (!ex_mem.ctrl.mem_read || ack_ok);

   assign wb = '{write: do_write,
                 dest:  ex_mem.dest,
                 data:  ex_mem.ctrl.mem_read ? wb_dat_i : ex_mem.result};

endmodule

`default_nettype wire

//--- hdl/proc.sv
/*
   Processor top level
   Four stages IF, ID, EX and MEM plus pipeline control
   Combinational instruction port, Wishbone classic data port
*/
`timescale 1ns/100ps
`default_nettype none

module proc #(
   parameter int PC_W = 8
) (
   input  wire logic              clk,
   input  wire logic              rst_n,
   output logic [PC_W-1:0]        imem_addr,
   input  wire proc_pkg::word_t   imem_data,
   output proc_pkg::bus_req_t     wb_req,
   input  wire proc_pkg::word_t   wb_dat_i,
   input  wire logic              wb_ack,
   output logic                   halt,
   output logic                   err
);
   import proc_pkg::*;

   instr_t  if_instr;
   word_t   if_pc;
   logic    if_valid;
   ctrl_t   ctrl;
   logic    stall;
   logic    flush;
   logic    freeze;
   logic    branch_taken;
   word_t   branch_target;
   logic    mem_busy;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_t     wb;

   pipe_control pipe_control_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .instr        (if_instr),
      .ex_dest      (id_ex.dest),
      .mem_dest     (ex_mem.dest),
      .ex_wr        (id_ex.valid && id_ex.ctrl.reg_write),
      .mem_wr       (ex_mem.valid && ex_mem.ctrl.reg_write),
      .branch_taken (branch_taken),
      .mem_busy     (mem_busy),
      .halted       (halt),
      .ctrl         (ctrl),
      .stall        (stall),
      .flush        (flush),
      .freeze       (freeze),
      .err          (err)
   );

   fetch_stage #(.PC_W(PC_W)) fetch_stage_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .imem_addr     (imem_addr),
      .imem_data     (imem_data),
      .stall         (stall),
      .flush         (flush),
      .freeze        (freeze),
      .halted        (halt),
      .branch_taken  (branch_taken),
      .branch_target (branch_target[PC_W-1:0]),   // Instruction space is PC_W wide
      .if_instr      (if_instr),
      .if_pc         (if_pc),
      .if_valid      (if_valid)
   );

   decode_stage decode_stage_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .if_instr (if_instr),
      .if_pc    (if_pc),
      .if_valid (if_valid),
      .ctrl     (ctrl),
      .stall    (stall),
      .flush    (flush),
      .freeze   (freeze),
      .wb       (wb),
      .id_ex    (id_ex)
   );

   execute_stage execute_stage_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .id_ex         (id_ex),
      .freeze        (freeze),
      .branch_taken  (branch_taken),
      .branch_target (branch_target),
      .ex_mem        (ex_mem)
   );

   mem_stage mem_stage_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .ex_mem   (ex_mem),
      .wb_req   (wb_req),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .mem_busy (mem_busy),
      .halted   (halt),
      .wb       (wb)
   );

endmodule

`default_nettype wire

//--- bench/clk_gen.sv
/*
   Clock and reset source for the testbench
   100 ns clock, active-low reset held for 5 cycles
   Reset restarts whenever rst_req is seen high
*/
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
   output logic      clk,
   output logic      rst_n,
   input  wire logic rst_req
);
   logic [2:0] cnt;

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      cnt   = 3'd5;
   end

   always #50 clk = ~clk;

   always @(posedge clk) begin
      if (rst_req) begin
         cnt   <= 3'd5;
         rst_n <= 1'b0;
      end else if (cnt != 3'd0) begin
         cnt   <= cnt - 3'd1;
         rst_n <= (cnt == 3'd1);   // Released on the fifth edge
      end
   end

endmodule

`default_nettype wire

//--- bench/proc_assert.sv
/*
   Concurrent checks on the Wishbone master and the halt latch
   Bound into mem_stage
*/
`timescale 1ns/100ps
`default_nettype none

module proc_assert (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire proc_pkg::bus_req_t req,
   input  wire logic               ack,
   input  wire logic               halted
);
   int fail_count = 0;

   // Master lets go of the bus the clock after ack
   cyc_drops_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
      (req.cyc && ack) |=> !req.cyc)
      else begin
         $error("cyc still high after ack");
         fail_count++;
      end

   // Request fields hold while the slave inserts wait states
   req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (req.stb && !ack) |=> (req.adr === $past(req.adr) && req.we === $past(req.we) &&
                             req.dat === $past(req.dat)))
      else begin
         $error("request changed before ack");
         fail_count++;
      end

   no_cycle_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
      (halted && !req.cyc) |=> !req.cyc)
      else begin
         $error("bus cycle started after halt");
         fail_count++;
      end

   halt_sticky: assert property (@(posedge clk) $fell(halted) |-> !rst_n)
      else begin
         $error("halt fell without reset");
         fail_count++;
      end

endmodule

bind mem_stage proc_assert proc_assert_inst (
   .clk    (clk),
   .rst_n  (rst_n),
   .req    (wb_req),
   .ack    (wb_ack),
   .halted (halted)
);

`default_nettype wire

//--- bench/proc_tb.sv
/*
   Testbench for the pipelined processor
   Instruction memory and Wishbone slave models with optional wait states
   Directed tests for ALU, RAW hazards, branches, loads, halt and err
   Compare tasks, per-test report and cycle limit
*/
`timescale 1ns/100ps
`default_nettype none

module proc_tb;
   import proc_pkg::*;

   localparam int LIMIT = 6 * (16 * 6) + 200;   // Cycles for the whole run

   logic       clk;
   logic       rst_n;
   logic       rst_req;
   logic [7:0] imem_addr;
   word_t      imem_data;
   bus_req_t   wb_req;
   word_t      wb_dat_i;
   logic       wb_ack;
   logic       halt;
   logic       err;

   word_t      imem [256];
   word_t      dmem [256];
   int         n_words;
   logic       busy;
   logic [1:0] wait_cnt;
   logic       waits_on;
   integer     seed = 20421;
   int         cycles;
   int         checks;
   int         errors;

   clk_gen clk_gen_inst (.clk(clk), .rst_n(rst_n), .rst_req(rst_req));

   proc #(.PC_W(8)) proc_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .wb_req    (wb_req),
      .wb_dat_i  (wb_dat_i),
      .wb_ack    (wb_ack),
      .halt      (halt),
      .err       (err)
   );

   assign imem_data = imem[imem_addr];
   // Unknown address reads as zero, so the first load clears r0
   assign wb_dat_i = $isunknown(wb_req.adr) ? 16'h0000 : dmem[wb_req.adr[7:0]];

   always @(posedge clk) begin
      if (!rst_n) begin
         wb_ack <= 1'b0;
         busy   <= 1'b0;
      end else if (wb_ack) begin
         if (wb_req.we) dmem[wb_req.adr[7:0]] <= wb_req.dat;   // Store lands on ack
         wb_ack <= 1'b0;
         busy   <= 1'b0;
      end else if (wb_req.cyc && wb_req.stb) begin
         if (!busy) begin
            busy     <= 1'b1;
            wait_cnt <= waits_on ? 2'($random(seed)) : 2'd0;
         end else if (wait_cnt == 2'd0) begin
            wb_ack <= 1'b1;
         end else begin
            wait_cnt <= wait_cnt - 2'd1;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: processor did not halt within %0d cycles", LIMIT);
         $display("Done: errors found");
         $finish;
      end
   end

   function automatic word_t fill_word(input logic [7:0] a);
      return {~a, a} ^ 16'h5A00;
   endfunction

   function automatic word_t r_word(input logic [1:0] fn, input reg_idx_t rs, rt, rd);
      return {OP_ADD_R, rs, rt, rd, fn};
   endfunction

   function automatic word_t i_word(input logic [4:0] op, input reg_idx_t rs, rd,
                                    input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic word_t b_word(input reg_idx_t rs, input logic [7:0] off);
      return {OP_BEQZ, rs, off};
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   task automatic emit(input word_t w);
      imem[n_words] = w;
      n_words++;
   endtask

   // Fresh memories and a preamble that zeroes r0
   task automatic new_program();
      for (int a = 0; a < 256; a++) begin
         imem[a] = {OP_NOP, 11'd0};
         dmem[a] = fill_word(8'(a));
      end
      n_words = 0;
      emit(i_word(OP_LD, 3'd0, 3'd0, 5'd0));
      emit(r_word(FN_XOR, 3'd0, 3'd0, 3'd0));
   endtask

   task automatic run_program();
      @(posedge clk);
      rst_req <= 1'b1;
      @(posedge clk);
      rst_req <= 1'b0;
      do @(posedge clk); while (rst_n !== 1'b1);
      while (halt !== 1'b1) @(posedge clk);
   endtask

   task automatic report(input string name, input int err_before);
      $display("%s: %s", name, (errors == err_before) ? "pass" : "FAIL");
   endtask

   task automatic arith_test();
      int    e0;
      word_t a;
      word_t b;
      e0 = errors;
      a  = 16'd13;
      b  = -16'sd6;
      new_program();
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd13));
      emit(i_word(OP_ADDI, 3'd0, 3'd2, 5'b11010));   // -6
      emit(r_word(FN_ADD, 3'd1, 3'd2, 3'd3));
      emit(r_word(FN_SUB, 3'd1, 3'd2, 3'd4));
      emit(r_word(FN_AND, 3'd1, 3'd2, 3'd5));
      emit(r_word(FN_XOR, 3'd1, 3'd2, 3'd6));
      for (int r = 1; r <= 6; r++) begin
         if (r != 2) emit(i_word(OP_ST, 3'd0, 3'(r), 5'(r)));
      end
      emit({OP_HALT, 11'd0});
      run_program();
      check_word("dmem[1]", a, dmem[1]);
      check_word("dmem[3]", a + b, dmem[3]);
      check_word("dmem[4]", a - b, dmem[4]);
      check_word("dmem[5]", a & b, dmem[5]);
      check_word("dmem[6]", a ^ b, dmem[6]);
      check_flag("err", 1'b0, err);
      report("arith", e0);
   endtask

   task automatic raw_test();
      int    e0;
      word_t r1;
      word_t r2;
      word_t r3;
      word_t r4;
      e0 = errors;
      r1 = 16'd5;
      r2 = r1 + r1;
      r3 = r2 - r1;
      r4 = r3 ^ r2;
      new_program();
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd5));
      emit(r_word(FN_ADD, 3'd1, 3'd1, 3'd2));
      emit(r_word(FN_SUB, 3'd2, 3'd1, 3'd3));
      emit(r_word(FN_XOR, 3'd3, 3'd2, 3'd4));
      emit(i_word(OP_ST, 3'd0, 3'd4, 5'd1));
      emit(r_word(FN_AND, 3'd4, 3'd2, 3'd5));
      emit(i_word(OP_ST, 3'd0, 3'd5, 5'd2));
      emit(i_word(OP_ST, 3'd0, 3'd3, 5'd3));
      emit({OP_HALT, 11'd0});
      run_program();
      check_word("dmem[1]", r4, dmem[1]);
      check_word("dmem[2]", r4 & r2, dmem[2]);
      check_word("dmem[3]", r3, dmem[3]);
      report("raw", e0);
   endtask

   task automatic branch_test();
      int e0;
      e0 = errors;
      new_program();
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd3));    // 2
      emit(b_word(3'd1, 8'd1));                   // 3 not taken
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd1));      // 4
      emit(b_word(3'd0, 8'd2));                   // 5 taken to 5 + 1 + 2
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd2));      // 6 skipped
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd3));      // 7 skipped
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd4));      // 8
      emit({OP_HALT, 11'd0});
      run_program();
      check_word("dmem[1]", 16'd3, dmem[1]);
      check_word("dmem[2]", fill_word(8'd2), dmem[2]);
      check_word("dmem[3]", fill_word(8'd3), dmem[3]);
      check_word("dmem[4]", 16'd3, dmem[4]);
      report("branch", e0);
   endtask

   task automatic load_test();
      int    e0;
      word_t x;
      word_t y;
      e0       = errors;
      x        = 16'h1234;
      y        = 16'h0F0F;
      waits_on = 1'b1;
      new_program();
      dmem[10] = x;
      dmem[11] = y;
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd10));
      emit(i_word(OP_LD, 3'd1, 3'd2, 5'd0));
      emit(i_word(OP_LD, 3'd1, 3'd3, 5'd1));
      emit(r_word(FN_ADD, 3'd2, 3'd3, 3'd4));
      emit(r_word(FN_XOR, 3'd2, 3'd3, 3'd5));
      emit(i_word(OP_ST, 3'd1, 3'd4, 5'd2));
      emit(i_word(OP_ST, 3'd1, 3'd5, 5'd3));
      emit(i_word(OP_ST, 3'd1, 3'd2, 5'd4));
      emit({OP_HALT, 11'd0});
      run_program();
      check_word("dmem[12]", x + y, dmem[12]);
      check_word("dmem[13]", x ^ y, dmem[13]);
      check_word("dmem[14]", x, dmem[14]);
      report("load", e0);
   endtask

   task automatic halt_test();
      int e0;
      e0 = errors;
      new_program();
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd9));
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd1));
      emit({OP_HALT, 11'd0});
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd2));
      emit(i_word(OP_ST, 3'd0, 3'd1, 5'd3));
      run_program();
      repeat (10) @(posedge clk);
      check_flag("halt", 1'b1, halt);
      check_word("dmem[1]", 16'd9, dmem[1]);
      check_word("dmem[2]", fill_word(8'd2), dmem[2]);
      check_word("dmem[3]", fill_word(8'd3), dmem[3]);
      report("halt", e0);
   endtask

   task automatic illegal_test();
      int e0;
      e0 = errors;
      new_program();
      emit(i_word(OP_ADDI, 3'd0, 3'd1, 5'd4));
      emit({5'b11111, 11'h2A5});   // Undefined opcode
      emit(i_word(OP_ADDI, 3'd1, 3'd2, 5'd3));
      emit(i_word(OP_ST, 3'd0, 3'd2, 5'd1));
      emit({OP_HALT, 11'd0});
      run_program();
      check_flag("err", 1'b1, err);
      check_word("dmem[1]", 16'd7, dmem[1]);
      report("illegal", e0);
   endtask

   initial begin
      rst_req  = 1'b0;
      wb_ack   = 1'b0;
      waits_on = 1'b0;
      cycles   = 0;
      checks   = 0;
      errors   = 0;
      arith_test();
      raw_test();
      branch_test();
      load_test();
      halt_test();
      illegal_test();
      errors += proc_inst.mem_stage_inst.proc_assert_inst.fail_count;
      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
hdl/proc_pkg.sv
hdl/pipe_control.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/proc.sv
bench/clk_gen.sv
bench/proc_assert.sv
bench/proc_tb.sv

//--- Bender.yml
package:
  name: proc

sources:
  - hdl/proc_pkg.sv
  - hdl/pipe_control.sv
  - hdl/fetch_stage.sv
  - hdl/decode_stage.sv
  - hdl/execute_stage.sv
  - hdl/mem_stage.sv
  - hdl/proc.sv
  - target: simulation
    files:
      - bench/clk_gen.sv
      - bench/proc_assert.sv
      - bench/proc_tb.sv
